// ==== include/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Address and line widths
`define DC_ADDR_BITS 32
`define DC_BLOCK_BITS 64

// Direct-mapped geometry, 32 lines of 8 bytes
`define DC_LINES 32
`define DC_OFFSET_BITS 3
`define DC_INDEX_BITS 5
`define DC_TAG_BITS 24

// Memory transaction tags, zero means no tag
`define DC_MEM_TAG_BITS 4

`endif

// ==== hw/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

    // Access size of a load or store
    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_e;

    // Command sent to memory
    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } mem_command_e;

    // Miss handler state
    typedef enum logic [1:0] {
        IDLE      = 2'h0,
        SEND_LOAD = 2'h1,
        WAIT_DATA = 2'h2
    } mshr_state_e;

    // The one outstanding miss
    typedef struct packed {
        logic [`DC_ADDR_BITS-1:0]    addr;
        logic [`DC_BLOCK_BITS-1:0]   data;
        mem_size_e                   size;
        logic                        is_store;
        logic [`DC_MEM_TAG_BITS-1:0] mem_tag;
        mshr_state_e                 state;
    } mshr_t;

endpackage

// ==== hw/dcache_port_if.sv ====
`include "dcache_consts.svh"

interface dcache_port_if;

    // Lookup path, answered combinationally
    logic [`DC_ADDR_BITS-1:0]  lookup_addr;
    logic                      hit;
    logic [`DC_BLOCK_BITS-1:0] hit_block;

    // Full line write, lands on the next edge
    logic                      wr_en;
    logic [`DC_ADDR_BITS-1:0]  wr_addr;
    logic [`DC_BLOCK_BITS-1:0] wr_block;

    modport ctrl (
        output lookup_addr,
        input  hit,
        input  hit_block,
        output wr_en,
        output wr_addr,
        output wr_block
    );

    modport array (
        input  lookup_addr,
        output hit,
        output hit_block,
        input  wr_en,
        input  wr_addr,
        input  wr_block
    );

endinterface

// ==== hw/lane_align.sv ====
`include "dcache_consts.svh"

module lane_align (
    input  logic [`DC_BLOCK_BITS-1:0]  base_block,
    input  logic [`DC_OFFSET_BITS-1:0] offset,
    input  dcache_pkg::mem_size_e      size,
    input  logic [`DC_BLOCK_BITS-1:0]  store_data,
    output logic [`DC_BLOCK_BITS-1:0]  merged_block,
    output logic [`DC_BLOCK_BITS-1:0]  load_data
);

    localparam int BYTES = `DC_BLOCK_BITS / 8;

    logic [BYTES-1:0]          size_mask;
    logic [BYTES-1:0]          lane_mask;
    logic [`DC_BLOCK_BITS-1:0] shifted_store;
    logic [`DC_BLOCK_BITS-1:0] shifted_base;

    // Bytes covered by the access, before placement
    always_comb begin
        case (size)
            dcache_pkg::BYTE:   size_mask = BYTES'(8'h01);
            dcache_pkg::HALF:   size_mask = BYTES'(8'h03);
            dcache_pkg::WORD:   size_mask = BYTES'(8'h0f);
            default:            size_mask = '1;
        endcase
    end

    assign lane_mask     = size_mask << offset;
    assign shifted_store = store_data << {offset, 3'b000};
    assign shifted_base  = base_block >> {offset, 3'b000};

    // Store path, selected lanes come from the store data
    always_comb begin
        for (int i = 0; i < BYTES; i++) begin
            if (lane_mask[i]) begin
                merged_block[i*8 +: 8] = shifted_store[i*8 +: 8];
            end else begin
                merged_block[i*8 +: 8] = base_block[i*8 +: 8];
            end
        end
    end

    // Load path, zero extended
    always_comb begin
        for (int i = 0; i < BYTES; i++) begin
            if (size_mask[i]) begin
                load_data[i*8 +: 8] = shifted_base[i*8 +: 8];
            end else begin
                load_data[i*8 +: 8] = 8'h00;
            end
        end
    end

endmodule

// ==== hw/dcache_array.sv ====
`include "dcache_consts.svh"

module dcache_array (
    input logic          clock,
    input logic          reset,
    dcache_port_if.array port
);

    localparam int INDEX_LO = `DC_OFFSET_BITS;
    localparam int INDEX_HI = `DC_OFFSET_BITS + `DC_INDEX_BITS - 1;
    localparam int TAG_LO   = `DC_OFFSET_BITS + `DC_INDEX_BITS;

    logic [`DC_LINES-1:0]      valid_bits;
    logic [`DC_TAG_BITS-1:0]   tags  [`DC_LINES];
    logic [`DC_BLOCK_BITS-1:0] lines [`DC_LINES];

    logic [`DC_INDEX_BITS-1:0] lookup_index;
    logic [`DC_TAG_BITS-1:0]   lookup_tag;
    logic [`DC_INDEX_BITS-1:0] wr_index;
    logic [`DC_TAG_BITS-1:0]   wr_tag;

    // Address split
    assign lookup_index = port.lookup_addr[INDEX_HI:INDEX_LO];
    assign lookup_tag   = port.lookup_addr[`DC_ADDR_BITS-1:TAG_LO];
    assign wr_index     = port.wr_addr[INDEX_HI:INDEX_LO];
    assign wr_tag       = port.wr_addr[`DC_ADDR_BITS-1:TAG_LO];

    // Hit detection on the indexed line
    assign port.hit       = valid_bits[lookup_index] && (tags[lookup_index] == lookup_tag);
    assign port.hit_block = lines[lookup_index];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (port.wr_en) begin
            valid_bits[wr_index] <= 1'b1;
        end
    end

    // Tag and data storage
    always_ff @(posedge clock) begin
        if (port.wr_en) begin
            tags[wr_index]  <= wr_tag;
            lines[wr_index] <= port.wr_block;
        end
    end

    // The handler must present a defined line address with every write
    a_wr_addr_known: assert property (
        @(posedge clock) disable iff (reset)
        port.wr_en |-> !$isunknown(port.wr_addr)
    ) else $error("dcache_array: wr_addr unknown during write");

endmodule

// ==== hw/miss_handler.sv ====
`include "dcache_consts.svh"

module miss_handler (
    input  logic                             clock,
    input  logic                             reset,

    // Requester
    input  logic                             req_valid,
    input  logic [`DC_ADDR_BITS-1:0]         req_addr,
    input  logic [`DC_BLOCK_BITS-1:0]        req_data,
    input  dcache_pkg::mem_size_e            req_size,
    input  logic                             req_is_store,
    output logic                             resp_valid,
    output logic [`DC_BLOCK_BITS-1:0]        resp_data,
    output logic                             stall,

    // Memory
    output dcache_pkg::mem_command_e         proc2mem_command,
    output logic [`DC_ADDR_BITS-1:0]         proc2mem_addr,
    output logic [`DC_BLOCK_BITS-1:0]        proc2mem_data,
    input  logic [`DC_MEM_TAG_BITS-1:0]      mem2proc_transaction_tag,
    input  logic [`DC_MEM_TAG_BITS-1:0]      mem2proc_data_tag,
    input  logic [`DC_BLOCK_BITS-1:0]        mem2proc_data,

    // Tag and data array
    dcache_port_if.ctrl                      port,

    // Byte-lane aligner
    output logic [`DC_BLOCK_BITS-1:0]        base_block,
    output logic [`DC_OFFSET_BITS-1:0]       offset,
    output dcache_pkg::mem_size_e            size,
    output logic [`DC_BLOCK_BITS-1:0]        store_data,
    input  logic [`DC_BLOCK_BITS-1:0]        merged_block,
    input  logic [`DC_BLOCK_BITS-1:0]        load_data
);

    dcache_pkg::mshr_t mshr;
    dcache_pkg::mshr_t next_mshr;
    logic              fill_match;
    logic              idle;

    function automatic logic [`DC_ADDR_BITS-1:0] block_base(input logic [`DC_ADDR_BITS-1:0] a);
        return {a[`DC_ADDR_BITS-1:`DC_OFFSET_BITS], {`DC_OFFSET_BITS{1'b0}}};
    endfunction

    assign idle       = (mshr.state == dcache_pkg::IDLE);
    assign fill_match = (mshr.state == dcache_pkg::WAIT_DATA) && (mem2proc_data_tag == mshr.mem_tag);
    assign stall      = !idle;

    // Hits only count while idle, so the live request drives the lookup
    assign port.lookup_addr = req_addr;

    // Aligner sees the request on a hit and the MSHR with the returned block on a fill
    assign base_block = idle ? port.hit_block : mem2proc_data;
    assign offset     = idle ? req_addr[`DC_OFFSET_BITS-1:0] : mshr.addr[`DC_OFFSET_BITS-1:0];
    assign size       = idle ? req_size : mshr.size;
    assign store_data = idle ? req_data : mshr.data;

    assign resp_data = load_data;

    always_comb begin
        next_mshr        = mshr;
        proc2mem_command = dcache_pkg::MEM_NONE;
        proc2mem_addr    = '0;
        proc2mem_data    = '0;
        resp_valid       = 1'b0;
        port.wr_en       = 1'b0;
        port.wr_addr     = mshr.addr;
        port.wr_block    = merged_block;

        case (mshr.state)
            dcache_pkg::IDLE: begin
                if (req_valid && port.hit) begin
                    if (req_is_store) begin
                        // Store hit updates the line and writes through together
                        proc2mem_command = dcache_pkg::MEM_STORE;
                        proc2mem_addr    = block_base(req_addr);
                        proc2mem_data    = merged_block;
                        port.wr_en       = 1'b1;
                        port.wr_addr     = req_addr;
                    end else begin
                        resp_valid = 1'b1;
                    end
                end else if (req_valid) begin
                    // Miss tries the block load right away
                    proc2mem_command   = dcache_pkg::MEM_LOAD;
                    proc2mem_addr      = block_base(req_addr);
                    next_mshr.addr     = req_addr;
                    next_mshr.data     = req_data;
                    next_mshr.size     = req_size;
                    next_mshr.is_store = req_is_store;
                    next_mshr.mem_tag  = mem2proc_transaction_tag;
                    if (mem2proc_transaction_tag != '0) begin
                        next_mshr.state = dcache_pkg::WAIT_DATA;
                    end else begin
                        next_mshr.state = dcache_pkg::SEND_LOAD;
                    end
                end
            end

            dcache_pkg::SEND_LOAD: begin
                // Load was refused, so keep asking
                proc2mem_command  = dcache_pkg::MEM_LOAD;
                proc2mem_addr     = block_base(mshr.addr);
                next_mshr.mem_tag = mem2proc_transaction_tag;
                if (mem2proc_transaction_tag != '0) begin
                    next_mshr.state = dcache_pkg::WAIT_DATA;
                end
            end

            dcache_pkg::WAIT_DATA: begin
                if (fill_match) begin
                    port.wr_en = 1'b1;
                    if (mshr.is_store) begin
                        proc2mem_command = dcache_pkg::MEM_STORE;
                        proc2mem_addr    = block_base(mshr.addr);
                        proc2mem_data    = merged_block;
                    end else begin
                        // Load fill keeps the block exactly as returned
                        port.wr_block = mem2proc_data;
                        resp_valid    = 1'b1;
                    end
                    next_mshr.mem_tag = '0;
                    next_mshr.state   = dcache_pkg::IDLE;
                end
            end

            default: begin
                next_mshr.state = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mshr.state   <= dcache_pkg::IDLE;
            mshr.mem_tag <= '0;
        end else begin
            mshr <= next_mshr;
        end
    end

    // Nothing goes to memory while the miss waits for its data
    a_quiet_in_wait: assert property (
        @(posedge clock) disable iff (reset)
        (mshr.state == dcache_pkg::WAIT_DATA && !fill_match)
            |-> proc2mem_command == dcache_pkg::MEM_NONE
    ) else $error("miss_handler: command issued while waiting for data");

    a_resp_or_store: assert property (
        @(posedge clock) disable iff (reset)
        !(resp_valid && proc2mem_command == dcache_pkg::MEM_STORE)
    ) else $error("miss_handler: response and store in the same cycle");

    // A refused load never reaches WAIT_DATA
    a_wait_has_tag: assert property (
        @(posedge clock) disable iff (reset)
        (mshr.state == dcache_pkg::WAIT_DATA) |-> (mshr.mem_tag != '0)
    ) else $error("miss_handler: WAIT_DATA with a zero memory tag");

endmodule

// ==== hw/dcache_top.sv ====
`include "dcache_consts.svh"

module dcache_top (
    input  logic                        clock,
    input  logic                        reset,

    input  logic                        req_valid,
    input  logic [`DC_ADDR_BITS-1:0]    req_addr,
    input  logic [`DC_BLOCK_BITS-1:0]   req_data,
    input  dcache_pkg::mem_size_e       req_size,
    input  logic                        req_is_store,
    output logic                        resp_valid,
    output logic [`DC_BLOCK_BITS-1:0]   resp_data,
    output logic                        stall,

    output dcache_pkg::mem_command_e    proc2mem_command,
    output logic [`DC_ADDR_BITS-1:0]    proc2mem_addr,
    output logic [`DC_BLOCK_BITS-1:0]   proc2mem_data,
    input  logic [`DC_MEM_TAG_BITS-1:0] mem2proc_transaction_tag,
    input  logic [`DC_MEM_TAG_BITS-1:0] mem2proc_data_tag,
    input  logic [`DC_BLOCK_BITS-1:0]   mem2proc_data
);

    // Aligner wiring
    logic [`DC_BLOCK_BITS-1:0]  base_block;
    logic [`DC_OFFSET_BITS-1:0] offset;
    dcache_pkg::mem_size_e      size;
    logic [`DC_BLOCK_BITS-1:0]  store_data;
    logic [`DC_BLOCK_BITS-1:0]  merged_block;
    logic [`DC_BLOCK_BITS-1:0]  load_data;

    dcache_port_if cache_port ();

    dcache_array u_array (
        .clock (clock),
        .reset (reset),
        .port  (cache_port.array)
    );

    miss_handler u_handler (
        .clock                    (clock),
        .reset                    (reset),
        .req_valid                (req_valid),
        .req_addr                 (req_addr),
        .req_data                 (req_data),
        .req_size                 (req_size),
        .req_is_store             (req_is_store),
        .resp_valid               (resp_valid),
        .resp_data                (resp_data),
        .stall                    (stall),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data),
        .port                     (cache_port.ctrl),
        .base_block               (base_block),
        .offset                   (offset),
        .size                     (size),
        .store_data               (store_data),
        .merged_block             (merged_block),
        .load_data                (load_data)
    );

    lane_align u_align (
        .base_block   (base_block),
        .offset       (offset),
        .size         (size),
        .store_data   (store_data),
        .merged_block (merged_block),
        .load_data    (load_data)
    );

endmodule

// ==== verif/mem_responder.sv ====
`include "dcache_consts.svh"

module mem_responder (
    input  logic                        clock,
    input  logic                        reset,
    input  dcache_pkg::mem_command_e    proc2mem_command,
    input  logic [`DC_ADDR_BITS-1:0]    proc2mem_addr,
    input  logic [`DC_BLOCK_BITS-1:0]   proc2mem_data,
    output logic [`DC_MEM_TAG_BITS-1:0] mem2proc_transaction_tag,
    output logic [`DC_MEM_TAG_BITS-1:0] mem2proc_data_tag,
    output logic [`DC_BLOCK_BITS-1:0]   mem2proc_data,
    output int                          refusals
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`DC_BLOCK_BITS-1:0]   image [logic [`DC_ADDR_BITS-1:0]];
    int                          seed = 32'h95da_9307;
    logic                        refuse = 1'b0;
    int                          delay_draw = 2;
    logic [`DC_MEM_TAG_BITS-1:0] next_tag;
    logic                        pending;
    logic                        due;
    logic [`DC_MEM_TAG_BITS-1:0] pend_tag;
    logic [`DC_ADDR_BITS-1:0]    pend_addr;
    int                          delay;

    // Contents of a block never written
    function automatic logic [`DC_BLOCK_BITS-1:0] initial_block(input logic [31:0] addr);
        return {addr * 32'h9e37_79b9, ~addr ^ 32'h5a5a_c3c3};
    endfunction

    function automatic logic [`DC_BLOCK_BITS-1:0] read_block(input logic [31:0] addr);
        if (image.exists(addr)) begin
            return image[addr];
        end
        return initial_block(addr);
    endfunction

    // Same-cycle answer, zero refuses a load
    always_comb begin
        if (proc2mem_command == dcache_pkg::MEM_LOAD && refuse) begin
            mem2proc_transaction_tag = '0;
        end else if (proc2mem_command != dcache_pkg::MEM_NONE) begin
            mem2proc_transaction_tag = next_tag;
        end else begin
            mem2proc_transaction_tag = '0;
        end
    end

    // Accept commands and count down the open load
    always @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'd1;
            pending  <= 1'b0;
            due      <= 1'b0;
            refusals <= 0;
        end else begin
            due <= 1'b0;
            if (pending) begin
                if (delay == 1) begin
                    due     <= 1'b1;
                    pending <= 1'b0;
                end
                delay <= delay - 1;
            end
            if (proc2mem_command == dcache_pkg::MEM_LOAD) begin
                if (mem2proc_transaction_tag == '0) begin
                    refusals <= refusals + 1;
                end else begin
                    pending   <= 1'b1;
                    pend_tag  <= mem2proc_transaction_tag;
                    pend_addr <= proc2mem_addr;
                    delay     <= delay_draw;
                    next_tag  <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                end
            end else if (proc2mem_command == dcache_pkg::MEM_STORE) begin
                image[proc2mem_addr] = proc2mem_data;
            end
        end
    end

    // Outputs change on the falling edge
    always @(negedge clock) begin
        refuse     <= ($unsigned($random(seed)) % 4) == 0;
        delay_draw <= 2 + int'($unsigned($random(seed)) % 5);
        if (!reset && due) begin
            mem2proc_data_tag <= pend_tag;
            mem2proc_data     <= read_block(pend_addr);
        end else begin
            mem2proc_data_tag <= '0;
            mem2proc_data     <= '0;
        end
    end

endmodule

// ==== verif/dcache_tb.sv ====
`include "dcache_consts.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_OPS      = 26;

    // One table row, hit is the expected lookup result
    typedef struct packed {
        logic                      is_store;
        logic [`DC_ADDR_BITS-1:0]  addr;
        dcache_pkg::mem_size_e     size;
        logic [`DC_BLOCK_BITS-1:0] data;
        logic                      hit;
    } op_t;

    logic                        clock;
    logic                        reset;
    logic                        req_valid;
    logic [`DC_ADDR_BITS-1:0]    req_addr;
    logic [`DC_BLOCK_BITS-1:0]   req_data;
    dcache_pkg::mem_size_e       req_size;
    logic                        req_is_store;
    logic                        resp_valid;
    logic [`DC_BLOCK_BITS-1:0]   resp_data;
    logic                        stall;
    dcache_pkg::mem_command_e    proc2mem_command;
    logic [`DC_ADDR_BITS-1:0]    proc2mem_addr;
    logic [`DC_BLOCK_BITS-1:0]   proc2mem_data;
    logic [`DC_MEM_TAG_BITS-1:0] mem2proc_transaction_tag;
    logic [`DC_MEM_TAG_BITS-1:0] mem2proc_data_tag;
    logic [`DC_BLOCK_BITS-1:0]   mem2proc_data;
    int                          refusals;

    op_t                       ops [NUM_OPS];
    logic [`DC_BLOCK_BITS-1:0] shadow [logic [`DC_ADDR_BITS-1:0]];
    int                        mismatch_count;
    int                        failure_count;

    dcache_top DUT (.*);
    mem_responder memory (.*);

    always #(PERIOD / 2) clock = ~clock;

    function automatic logic [`DC_BLOCK_BITS-1:0] initial_block(input logic [31:0] addr);
        return {addr * 32'h9e37_79b9, ~addr ^ 32'h5a5a_c3c3};
    endfunction

    function automatic logic [`DC_BLOCK_BITS-1:0] shadow_block(input logic [31:0] base);
        if (shadow.exists(base)) begin
            return shadow[base];
        end
        return initial_block(base);
    endfunction

    // Bytes at the access lanes, zero extended
    function automatic logic [63:0] expected_load(input logic [31:0] addr,
                                                  input dcache_pkg::mem_size_e size);
        logic [63:0] block;
        logic [63:0] result;
        int          lane;
        block  = shadow_block({addr[31:3], 3'b000});
        result = '0;
        lane   = int'(addr[2:0]);
        for (int i = 0; i < (1 << size); i++) begin
            result[i*8 +: 8] = block[(lane + i)*8 +: 8];
        end
        return result;
    endfunction

    function automatic logic [63:0] merge_store(input logic [31:0] addr,
                                                input dcache_pkg::mem_size_e size,
                                                input logic [63:0] data);
        logic [63:0] block;
        int          lane;
        block = shadow_block({addr[31:3], 3'b000});
        lane  = int'(addr[2:0]);
        for (int i = 0; i < (1 << size); i++) begin
            block[(lane + i)*8 +: 8] = data[i*8 +: 8];
        end
        return block;
    endfunction

    task automatic expect_equal(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, got %h at %0t", name, expected, actual, $time);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        failure_count++;
    endtask

    task automatic load_table();
        ops[0]  = '{1'b0, 32'h0000_1000, dcache_pkg::WORD,   64'h0, 1'b0};
        ops[1]  = '{1'b0, 32'h0000_1004, dcache_pkg::WORD,   64'h0, 1'b1};
        ops[2]  = '{1'b0, 32'h0000_1001, dcache_pkg::BYTE,   64'h0, 1'b1};
        ops[3]  = '{1'b1, 32'h0000_1002, dcache_pkg::HALF,   64'hbeef, 1'b1};
        ops[4]  = '{1'b0, 32'h0000_1000, dcache_pkg::DOUBLE, 64'h0, 1'b1};
        ops[5]  = '{1'b1, 32'h0000_2010, dcache_pkg::WORD,   64'hcafe_f00d, 1'b0};
        ops[6]  = '{1'b0, 32'h0000_2010, dcache_pkg::WORD,   64'h0, 1'b1};
        ops[7]  = '{1'b0, 32'h0000_2014, dcache_pkg::HALF,   64'h0, 1'b1};
        // Same index as 0x1000, so these alternate and miss
        ops[8]  = '{1'b0, 32'h0000_3000, dcache_pkg::DOUBLE, 64'h0, 1'b0};
        ops[9]  = '{1'b0, 32'h0000_1000, dcache_pkg::DOUBLE, 64'h0, 1'b0};
        ops[10] = '{1'b0, 32'h0000_3006, dcache_pkg::HALF,   64'h0, 1'b0};
        ops[11] = '{1'b0, 32'h0000_1003, dcache_pkg::BYTE,   64'h0, 1'b0};
        ops[12] = '{1'b1, 32'h0000_4028, dcache_pkg::DOUBLE, 64'h0123_4567_89ab_cdef, 1'b0};
        ops[13] = '{1'b0, 32'h0000_4028, dcache_pkg::DOUBLE, 64'h0, 1'b1};
        ops[14] = '{1'b1, 32'h0000_402d, dcache_pkg::BYTE,   64'h5a, 1'b1};
        ops[15] = '{1'b0, 32'h0000_402c, dcache_pkg::WORD,   64'h0, 1'b1};
        ops[16] = '{1'b0, 32'h0000_5030, dcache_pkg::WORD,   64'h0, 1'b0};
        ops[17] = '{1'b1, 32'h0000_6038, dcache_pkg::HALF,   64'h1234, 1'b0};
        ops[18] = '{1'b0, 32'h0000_6038, dcache_pkg::HALF,   64'h0, 1'b1};
        ops[19] = '{1'b0, 32'h0000_7040, dcache_pkg::DOUBLE, 64'h0, 1'b0};
        ops[20] = '{1'b0, 32'h0000_8048, dcache_pkg::WORD,   64'h0, 1'b0};
        ops[21] = '{1'b1, 32'h0000_8048, dcache_pkg::WORD,   64'h7777_0001, 1'b1};
        ops[22] = '{1'b0, 32'h0000_0048, dcache_pkg::WORD,   64'h0, 1'b0};
        ops[23] = '{1'b0, 32'h0000_8048, dcache_pkg::WORD,   64'h0, 1'b0};
        ops[24] = '{1'b0, 32'h0000_9050, dcache_pkg::BYTE,   64'h0, 1'b0};
        ops[25] = '{1'b0, 32'h0000_6038, dcache_pkg::DOUBLE, 64'h0, 1'b1};
    endtask

    task automatic apply_op(input op_t op);
        logic [31:0] base;
        logic [63:0] exp_block;
        logic [63:0] exp_load;
        int          answers;
        int          stores;
        base      = {op.addr[31:3], 3'b000};
        exp_block = merge_store(op.addr, op.size, op.data);
        exp_load  = expected_load(op.addr, op.size);
        answers   = 0;
        stores    = 0;
        @(negedge clock);
        while (stall) begin
            @(negedge clock);
        end
        req_valid    = 1'b1;
        req_addr     = op.addr;
        req_data     = op.data;
        req_size     = op.size;
        req_is_store = op.is_store;
        #(PERIOD / 4);
        if (op.hit && op.is_store) begin
            expect_equal("proc2mem_command", 64'(dcache_pkg::MEM_STORE), 64'(proc2mem_command));
            expect_equal("proc2mem_addr", 64'(base), 64'(proc2mem_addr));
            expect_equal("proc2mem_data", exp_block, proc2mem_data);
        end else if (op.hit) begin
            expect_equal("resp_valid", 64'(1), 64'(resp_valid));
            expect_equal("resp_data", exp_load, resp_data);
        end else begin
            expect_equal("proc2mem_command", 64'(dcache_pkg::MEM_LOAD), 64'(proc2mem_command));
            expect_equal("proc2mem_addr", 64'(base), 64'(proc2mem_addr));
            expect_equal("resp_valid", 64'(0), 64'(resp_valid));
        end
        if (op.is_store) begin
            shadow[base] = exp_block;
        end
        @(negedge clock);
        req_valid = 1'b0;
        if (!op.hit) begin
            #(PERIOD / 4);
            if (!stall) begin
                report_failure("stall did not rise after a miss");
            end
            // Runs until the miss completes, the watchdog bounds it
            while (stall) begin
                if (resp_valid) begin
                    answers++;
                    expect_equal("resp_data", exp_load, resp_data);
                end
                if (proc2mem_command == dcache_pkg::MEM_STORE) begin
                    stores++;
                    expect_equal("proc2mem_addr", 64'(base), 64'(proc2mem_addr));
                    expect_equal("proc2mem_data", exp_block, proc2mem_data);
                end
                @(negedge clock);
                #(PERIOD / 4);
            end
            if (op.is_store && (stores != 1 || answers != 0)) begin
                report_failure($sformatf("store miss at %h gave %0d stores and %0d responses",
                                         op.addr, stores, answers));
            end
            if (!op.is_store && (answers != 1 || stores != 0)) begin
                report_failure($sformatf("load miss at %h gave %0d responses and %0d stores",
                                         op.addr, answers, stores));
            end
        end
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        req_valid      = 1'b0;
        req_addr       = '0;
        req_data       = '0;
        req_size       = dcache_pkg::BYTE;
        req_is_store   = 1'b0;
        mismatch_count = 0;
        failure_count  = 0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clock);
        #(PERIOD / 4);
        expect_equal("proc2mem_command", 64'(dcache_pkg::MEM_NONE), 64'(proc2mem_command));
        expect_equal("stall", 64'(0), 64'(stall));
        expect_equal("resp_valid", 64'(0), 64'(resp_valid));
        @(negedge clock);
        reset = 1'b0;
        for (int n = 0; n < NUM_OPS; n++) begin
            apply_op(ops[n]);
        end
        @(negedge clock);
        if (refusals == 0) begin
            report_failure("memory never refused a load, so the retry path was not used");
        end
        $display("Summary: %0d mismatches, %0d other errors, %0d refused loads",
                 mismatch_count, failure_count, refusals);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog, about 20 cycles per table row
    initial begin
        repeat (RESET_CYCLES + NUM_OPS * 20) @(posedge clock);
        $display("Timeout: run did not finish within %0d cycles", RESET_CYCLES + NUM_OPS * 20);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
hw/dcache_pkg.sv
hw/dcache_port_if.sv
hw/lane_align.sv
hw/dcache_array.sv
hw/miss_handler.sv
hw/dcache_top.sv
verif/mem_responder.sv
verif/dcache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dcache_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = All tests passed!
SOURCES   = $(wildcard hw/*.sv verif/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
